/* design/capture_pkg.sv */
package capture_pkg;

    // sample and word geometry
    localparam int SAMPLE_W         = 12;
    localparam int SAMPLES_PER_WORD = 3;
    localparam int WORD_W           = SAMPLE_W * SAMPLES_PER_WORD;

    localparam int SAMPLE_DEPTH = 16;   // sample FIFO entries
    localparam int WORD_DEPTH   = 8;    // word FIFO entries

    localparam int unsigned MAX_SAMPLES = 48;   // normal mode stop point

    localparam int SETTLE_CYCLES = 8;   // idle cycles after arm
    localparam int SETTLE_W      = $clog2(SETTLE_CYCLES);
    localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(SETTLE_CYCLES - 1);

    localparam int DS_W = 13;   // downsample field width

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [WORD_W-1:0]   word_t;   // oldest sample in the top bits

    typedef struct packed {
        logic            stream_mode;   // run until overflow
        logic            low_res;       // 8 bits per sample on readout
        logic            low_res_lsb;   // bottom 8 bits instead of top 8
        logic [DS_W-1:0] downsample;    // skip this many ticks between samples
    } capture_cfg_t;

    typedef struct packed {
        logic        capture_stop;
        logic        fifo_overflow;
        logic [31:0] samples;
    } capture_status_t;

endpackage

/* design/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16           // power of two
) (
    input  logic     adc_sampleclk,
    input  logic     arm_fifo_rst_adc,
    input  logic     wr_i,
    input  payload_t din_i,
    input  logic     rd_i,
    output payload_t dout_o,
    output logic     full_o,
    output logic     empty_o
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH):0]     count;
    logic                       do_wr;
    logic                       do_rd;

    assign full_o  = count[$clog2(DEPTH)];   // count == DEPTH
    assign empty_o = (count == '0);
    assign do_wr   = wr_i & ~full_o;    // drop on full
    assign do_rd   = rd_i & ~empty_o;   // ignore on empty

    // first word fall through
    assign dout_o = mem[rd_ptr];

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr] <= din_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (arm_fifo_rst_adc) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/capture_fsm.sv */
`timescale 1ns/1ps

module capture_fsm (
    input  logic                      adc_sampleclk,
    input  logic                      arm_fifo_rst_adc,
    input  capture_pkg::capture_cfg_t cfg_i,
    input  logic                      go_i,
    input  logic                      mask_i,
    input  logic                      settle_done_i,
    input  logic                      sample_tick_i,
    input  logic                      count_reached_i,
    input  logic                      sample_full_i,
    output logic                      capture_en_o,
    output logic                      sample_wr_o,
    output logic                      capture_stop_o,
    output logic                      fifo_overflow_o
);

    typedef enum logic [1:0] {
        SETTLE,
        ARMED,
        CAPTURE,
        STOPPED
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   ovf_event;

    assign capture_en_o   = (state_q == CAPTURE);
    assign sample_wr_o    = sample_tick_i & mask_i & capture_en_o;
    assign capture_stop_o = (state_q == STOPPED);
    assign ovf_event      = sample_wr_o & sample_full_i;   // sample dropped

    always_comb begin
        state_d = state_q;
        case (state_q)
            SETTLE: begin
                if (settle_done_i)
                    state_d = ARMED;
            end
            ARMED: begin
                if (go_i)
                    state_d = CAPTURE;
            end
            CAPTURE: begin
                if (!go_i)
                    state_d = STOPPED;
                else if (cfg_i.stream_mode && ovf_event)
                    state_d = STOPPED;   // stream runs until it falls behind
                else if (!cfg_i.stream_mode && count_reached_i)
                    state_d = STOPPED;
            end
            default: state_d = STOPPED;   // hold until next arm
        endcase
    end

    always_ff @(posedge adc_sampleclk) begin
        if (arm_fifo_rst_adc) begin
            state_q         <= SETTLE;
            fifo_overflow_o <= 1'b0;
        end else begin
            state_q <= state_d;
            if (ovf_event)
                fifo_overflow_o <= 1'b1;   // sticky until re-armed
        end
    end

endmodule

/* design/capture_timer.sv */
`timescale 1ns/1ps

module capture_timer (
    input  logic                         adc_sampleclk,
    input  logic                         arm_fifo_rst_adc,
    input  logic [capture_pkg::DS_W-1:0] downsample_i,
    input  logic                         go_i,
    input  logic                         capture_en_i,
    input  logic                         sample_wr_i,
    output logic                         settle_done_o,
    output logic                         sample_tick_o,
    output logic                         count_reached_o,
    output logic [31:0]                  samples_o
);

    logic [capture_pkg::SETTLE_W-1:0] settle_cnt;
    logic [capture_pkg::DS_W-1:0]     ds_cnt;
    logic                             ds_max;

    assign settle_done_o   = (settle_cnt == capture_pkg::SETTLE_LAST);
    assign ds_max          = (ds_cnt == downsample_i);
    assign sample_tick_o   = go_i & ds_max;
    // high on the write that makes the count reach the limit
    assign count_reached_o = sample_wr_i & (samples_o == capture_pkg::MAX_SAMPLES - 1);

    always_ff @(posedge adc_sampleclk) begin
        if (arm_fifo_rst_adc)
            settle_cnt <= '0;
        else if (!settle_done_o)
            settle_cnt <= settle_cnt + 1'b1;   // saturates at last settle cycle
    end

    // plain decimation counter, not a filter
    always_ff @(posedge adc_sampleclk) begin
        if (arm_fifo_rst_adc || !go_i || !capture_en_i || ds_max)
            ds_cnt <= '0;
        else
            ds_cnt <= ds_cnt + 1'b1;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (arm_fifo_rst_adc)
            samples_o <= '0;
        else if (sample_wr_i)
            samples_o <= samples_o + 32'd1;
    end

endmodule

/* design/sample_packer.sv */
`timescale 1ns/1ps

module sample_packer (
    input  logic                 adc_sampleclk,
    input  logic                 arm_fifo_rst_adc,
    input  capture_pkg::sample_t sample_i,
    input  logic                 sample_empty_i,
    input  logic                 word_full_i,
    output logic                 sample_rd_o,
    output capture_pkg::word_t   word_o,
    output logic                 word_wr_o
);

    capture_pkg::word_t word_q;
    logic [1:0]         phase;   // samples already in word_q, mod 3
    logic               last_pop;

    assign sample_rd_o = ~sample_empty_i & ~word_full_i;   // stall on full word FIFO
    assign last_pop    = sample_rd_o & (phase == 2'(capture_pkg::SAMPLES_PER_WORD - 1));
    assign word_o      = word_q;

    // newest sample shifts in at the bottom
    always_ff @(posedge adc_sampleclk) begin
        if (sample_rd_o)
            word_q <= {word_q[capture_pkg::WORD_W-capture_pkg::SAMPLE_W-1:0], sample_i};
    end

    always_ff @(posedge adc_sampleclk) begin
        if (arm_fifo_rst_adc) begin
            phase     <= '0;
            word_wr_o <= 1'b0;
        end else begin
            word_wr_o <= last_pop;   // word complete on the next cycle
            if (last_pop)
                phase <= '0;
            else if (sample_rd_o)
                phase <= phase + 2'd1;
        end
    end

endmodule

/* design/byte_unpacker.sv */
`timescale 1ns/1ps

module byte_unpacker (
    input  logic                      adc_sampleclk,
    input  logic                      arm_fifo_rst_adc,
    input  capture_pkg::capture_cfg_t cfg_i,
    input  capture_pkg::word_t        word_i,
    input  logic                      word_empty_i,
    output logic                      word_rd_o,
    input  logic                      read_en_i,
    output logic [7:0]                read_data_o,
    output logic                      read_valid_o,
    output logic                      read_empty_o
);

    // up to 7 leftover bits plus one full word
    logic [capture_pkg::WORD_W+6:0]                 res_q;
    logic [capture_pkg::WORD_W+6:0]                 load_bits;
    logic [5:0]                                     fill_q;   // valid bits, right aligned
    logic [5:0]                                     load_len;
    logic [8*capture_pkg::SAMPLES_PER_WORD-1:0]     low_bits;
    logic                                           byte_rd;

    assign read_empty_o = (fill_q < 6'd8);
    assign word_rd_o    = read_empty_o & ~word_empty_i;   // refill below one byte
    assign byte_rd      = read_en_i & ~read_empty_o;

    // 8 bits kept from each sample, oldest sample ends up on top
    always_comb begin
        for (int k = 0; k < capture_pkg::SAMPLES_PER_WORD; k++) begin
            if (cfg_i.low_res_lsb)
                low_bits[8*k +: 8] = word_i[capture_pkg::SAMPLE_W*k +: 8];
            else
                low_bits[8*k +: 8] = word_i[capture_pkg::SAMPLE_W*k + capture_pkg::SAMPLE_W - 8 +: 8];
        end
    end

    always_comb begin
        load_bits = '0;
        if (cfg_i.low_res) begin
            load_bits[8*capture_pkg::SAMPLES_PER_WORD-1:0] = low_bits;
            load_len = 6'(8 * capture_pkg::SAMPLES_PER_WORD);
        end else begin
            load_bits[capture_pkg::WORD_W-1:0] = word_i;   // whole 36 bit word
            load_len = 6'(capture_pkg::WORD_W);
        end
    end

    // refill and read never coincide, fill is below 8 on refill
    always_ff @(posedge adc_sampleclk) begin
        if (word_rd_o)
            res_q <= (res_q << load_len) | load_bits;
        if (byte_rd)
            read_data_o <= 8'(res_q >> (fill_q - 6'd8));   // msb first
    end

    always_ff @(posedge adc_sampleclk) begin
        if (arm_fifo_rst_adc) begin
            fill_q       <= '0;
            read_valid_o <= 1'b0;
        end else begin
            read_valid_o <= byte_rd;
            if (word_rd_o)
                fill_q <= fill_q + load_len;
            else if (byte_rd)
                fill_q <= fill_q - 6'd8;
        end
    end

endmodule

/* design/adc_capture_top.sv */
`timescale 1ns/1ps

module adc_capture_top (
    input  logic                         adc_sampleclk,
    input  logic                         arm_fifo_rst_adc,   // also the arm pulse
    input  capture_pkg::sample_t         adc_datain_i,
    input  logic                         adc_write_mask_i,
    input  logic                         adc_capture_go_i,
    input  capture_pkg::capture_cfg_t    cfg_i,
    input  logic                         fifo_read_en_i,
    output logic [7:0]                   fifo_read_data_o,
    output logic                         fifo_read_valid_o,
    output logic                         fifo_read_empty_o,
    output capture_pkg::capture_status_t status_o,
    output logic [31:0]                  max_samples_o
);

    logic                 settle_done;
    logic                 sample_tick;
    logic                 count_reached;
    logic                 capture_en;
    logic                 sample_wr;
    logic                 sample_rd;
    logic                 sample_full;
    logic                 sample_empty;
    capture_pkg::sample_t sample_dout;
    capture_pkg::word_t   word_din;
    capture_pkg::word_t   word_dout;
    logic                 word_wr;
    logic                 word_rd;
    logic                 word_full;
    logic                 word_empty;

    assign max_samples_o = capture_pkg::MAX_SAMPLES;

    capture_fsm u_fsm (
        .adc_sampleclk    (adc_sampleclk),
        .arm_fifo_rst_adc (arm_fifo_rst_adc),
        .cfg_i            (cfg_i),
        .go_i             (adc_capture_go_i),
        .mask_i           (adc_write_mask_i),
        .settle_done_i    (settle_done),
        .sample_tick_i    (sample_tick),
        .count_reached_i  (count_reached),
        .sample_full_i    (sample_full),
        .capture_en_o     (capture_en),
        .sample_wr_o      (sample_wr),
        .capture_stop_o   (status_o.capture_stop),
        .fifo_overflow_o  (status_o.fifo_overflow)
    );

    capture_timer u_timer (
        .adc_sampleclk    (adc_sampleclk),
        .arm_fifo_rst_adc (arm_fifo_rst_adc),
        .downsample_i     (cfg_i.downsample),
        .go_i             (adc_capture_go_i),
        .capture_en_i     (capture_en),
        .sample_wr_i      (sample_wr),
        .settle_done_o    (settle_done),
        .sample_tick_o    (sample_tick),
        .count_reached_o  (count_reached),
        .samples_o        (status_o.samples)
    );

    sync_fifo #(
        .payload_t (capture_pkg::sample_t),
        .DEPTH     (capture_pkg::SAMPLE_DEPTH)
    ) u_sample_fifo (
        .adc_sampleclk    (adc_sampleclk),
        .arm_fifo_rst_adc (arm_fifo_rst_adc),
        .wr_i             (sample_wr),
        .din_i            (adc_datain_i),
        .rd_i             (sample_rd),
        .dout_o           (sample_dout),
        .full_o           (sample_full),
        .empty_o          (sample_empty)
    );

    sample_packer u_packer (
        .adc_sampleclk    (adc_sampleclk),
        .arm_fifo_rst_adc (arm_fifo_rst_adc),
        .sample_i         (sample_dout),
        .sample_empty_i   (sample_empty),
        .word_full_i      (word_full),
        .sample_rd_o      (sample_rd),
        .word_o           (word_din),
        .word_wr_o        (word_wr)
    );

    sync_fifo #(
        .payload_t (capture_pkg::word_t),
        .DEPTH     (capture_pkg::WORD_DEPTH)
    ) u_word_fifo (
        .adc_sampleclk    (adc_sampleclk),
        .arm_fifo_rst_adc (arm_fifo_rst_adc),
        .wr_i             (word_wr),
        .din_i            (word_din),
        .rd_i             (word_rd),
        .dout_o           (word_dout),
        .full_o           (word_full),
        .empty_o          (word_empty)
    );

    byte_unpacker u_unpacker (
        .adc_sampleclk    (adc_sampleclk),
        .arm_fifo_rst_adc (arm_fifo_rst_adc),
        .cfg_i            (cfg_i),
        .word_i           (word_dout),
        .word_empty_i     (word_empty),
        .word_rd_o        (word_rd),
        .read_en_i        (fifo_read_en_i),
        .read_data_o      (fifo_read_data_o),
        .read_valid_o     (fifo_read_valid_o),
        .read_empty_o     (fifo_read_empty_o)
    );

endmodule

/* sim/capture_chk.sv */
`timescale 1ns/1ps

module capture_chk (
    input logic                         adc_sampleclk,
    input logic                         arm_fifo_rst_adc,
    input logic                         settle_done_i,
    input logic                         read_en_i,
    input logic                         read_empty_i,
    input logic                         read_valid_i,
    input capture_pkg::capture_status_t status_i
);

    int   fail_count = 0;   // read by the testbench at the end
    logic read_ok;

    assign read_ok = read_en_i & ~read_empty_i;   // byte actually taken

    a_valid_after_read: assert property (@(posedge adc_sampleclk)
        disable iff (arm_fifo_rst_adc) read_ok |=> read_valid_i)
    else begin
        fail_count++;
        $error("accepted read gave no valid byte");
    end

    a_no_valid_without_read: assert property (@(posedge adc_sampleclk)
        disable iff (arm_fifo_rst_adc) !read_ok |=> !read_valid_i)
    else begin
        fail_count++;
        $error("valid byte without an accepted read");
    end

    // overflow only clears on the next arm
    a_overflow_sticky: assert property (@(posedge adc_sampleclk)
        disable iff (arm_fifo_rst_adc) status_i.fifo_overflow |=> status_i.fifo_overflow)
    else begin
        fail_count++;
        $error("fifo_overflow cleared without reset");
    end

    a_no_stop_in_settle: assert property (@(posedge adc_sampleclk)
        disable iff (arm_fifo_rst_adc) !settle_done_i |-> !status_i.capture_stop)
    else begin
        fail_count++;
        $error("capture_stop high during settle");
    end

endmodule

/* sim/tb_adc_capture.sv */
`timescale 1ns/1ps

module tb_adc_capture;

    typedef struct packed {
        capture_pkg::capture_cfg_t cfg;
        logic [15:0]               go_cycles;
        logic                      stall;      // hold reads off while go is high
        logic                      exp_ovf;
        logic                      exp_full;   // normal run reaches MAX_SAMPLES
    } row_t;

    typedef enum {M_SETTLE, M_ARMED, M_CAPTURE, M_STOPPED} model_state_t;

    logic                         adc_sampleclk = 1'b0;
    logic                         arm_fifo_rst_adc;
    capture_pkg::sample_t         adc_datain_i;
    logic                         adc_write_mask_i;
    logic                         adc_capture_go_i;
    capture_pkg::capture_cfg_t    cfg_i;
    logic                         fifo_read_en_i;
    logic [7:0]                   fifo_read_data_o;
    logic                         fifo_read_valid_o;
    logic                         fifo_read_empty_o;
    capture_pkg::capture_status_t status_o;
    logic [31:0]                  max_samples_o;

    row_t                         rows [5];
    logic [31:0]                  rng_state = 32'ha9a6_2749;
    model_state_t                 m_state;
    int                           m_settle;
    logic [capture_pkg::DS_W-1:0] m_ds;
    int                           m_count;
    capture_pkg::sample_t         m_samples [$];   // every accepted sample
    logic [7:0]                   exp_bytes [$];
    logic [7:0]                   got_bytes [$];
    int                           err_count = 0;
    int                           check_count = 0;
    longint                       wd_cycles;

    adc_capture_top DUT (.*);

    bind adc_capture_top capture_chk u_chk (
        .adc_sampleclk    (adc_sampleclk),
        .arm_fifo_rst_adc (arm_fifo_rst_adc),
        .settle_done_i    (settle_done),
        .read_en_i        (fifo_read_en_i),
        .read_empty_i     (fifo_read_empty_o),
        .read_valid_i     (fifo_read_valid_o),
        .status_i         (status_o)
    );

    always #4 adc_sampleclk = ~adc_sampleclk;   // 8 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // complete words only, bytes in readout order
    task automatic build_expected(input capture_pkg::capture_cfg_t cfg);
        int                   nsamp;
        int                   nbits;
        logic [31:0]          acc;
        capture_pkg::sample_t s;
        exp_bytes.delete();
        nsamp = (m_samples.size() / capture_pkg::SAMPLES_PER_WORD)
                * capture_pkg::SAMPLES_PER_WORD;
        acc   = '0;
        nbits = 0;
        for (int i = 0; i < nsamp; i++) begin
            s = m_samples[i];
            if (cfg.low_res) begin
                exp_bytes.push_back(cfg.low_res_lsb ? s[7:0] : s[11:4]);
            end else begin
                acc   = (acc << capture_pkg::SAMPLE_W) | s;   // msb first stream
                nbits = nbits + capture_pkg::SAMPLE_W;
                while (nbits >= 8) begin
                    exp_bytes.push_back(8'(acc >> (nbits - 8)));
                    nbits = nbits - 8;
                end
            end
        end
    endtask

    // sees the inputs the DUT samples on the same edge
    always @(posedge adc_sampleclk) begin : ref_model
        if (arm_fifo_rst_adc) begin
            m_state  = M_SETTLE;
            m_settle = 0;
            m_ds     = '0;
            m_count  = 0;
            m_samples.delete();
        end else begin
            case (m_state)
                M_SETTLE: begin
                    if (m_settle == capture_pkg::SETTLE_CYCLES - 1)
                        m_state = M_ARMED;
                    else
                        m_settle++;
                end
                M_ARMED: begin
                    m_ds = '0;
                    if (adc_capture_go_i)
                        m_state = M_CAPTURE;
                end
                M_CAPTURE: begin
                    if (adc_capture_go_i && m_ds == cfg_i.downsample && adc_write_mask_i) begin
                        m_samples.push_back(adc_datain_i);
                        m_count++;
                    end
                    if (!adc_capture_go_i)
                        m_state = M_STOPPED;
                    else if (!cfg_i.stream_mode && m_count == capture_pkg::MAX_SAMPLES)
                        m_state = M_STOPPED;
                    if (!adc_capture_go_i || m_ds == cfg_i.downsample)
                        m_ds = '0;
                    else
                        m_ds = m_ds + 1'b1;
                end
                default: ;   // stopped until next arm
            endcase
        end
    end

    always @(negedge adc_sampleclk) begin : byte_monitor
        if (fifo_read_valid_o)
            got_bytes.push_back(fifo_read_data_o);
    end

    initial begin : main
        row_t  row;
        int    idle;
        int    waited;
        int    errs_before;
        string res_name;

        arm_fifo_rst_adc = 1'b1;
        adc_datain_i     = '0;
        adc_write_mask_i = 1'b0;
        adc_capture_go_i = 1'b0;
        cfg_i            = '0;
        fifo_read_en_i   = 1'b0;

        // {stream, low_res, lsb, downsample}, go cycles, stall, overflow, full run
        rows[0] = '{'{1'b0, 1'b0, 1'b0, 13'd0}, 16'd160, 1'b0, 1'b0, 1'b1};
        rows[1] = '{'{1'b0, 1'b1, 1'b0, 13'd0}, 16'd160, 1'b0, 1'b0, 1'b1};
        rows[2] = '{'{1'b0, 1'b1, 1'b1, 13'd0}, 16'd160, 1'b0, 1'b0, 1'b1};
        rows[3] = '{'{1'b0, 1'b0, 1'b0, 13'd3}, 16'd200, 1'b0, 1'b0, 1'b0};
        rows[4] = '{'{1'b1, 1'b0, 1'b0, 13'd0}, 16'd150, 1'b1, 1'b1, 1'b0};

        wd_cycles = 0;
        foreach (rows[i])
            wd_cycles += rows[i].go_cycles + 420;   // reset, settle and drain
        fork
            begin
                #(wd_cycles * 8 * 2);   // twice the expected run time
                $display("watchdog expired, the run timed out");
                $display("Simulation FAILED");
                $finish;
            end
        join_none

        foreach (rows[t]) begin
            row         = rows[t];
            errs_before = err_count;

            @(posedge adc_sampleclk);
            arm_fifo_rst_adc <= 1'b1;
            adc_capture_go_i <= 1'b0;
            adc_write_mask_i <= 1'b0;
            fifo_read_en_i   <= 1'b1;   // requests while still empty
            cfg_i            <= row.cfg;
            repeat (2) @(posedge adc_sampleclk);
            arm_fifo_rst_adc <= 1'b0;
            got_bytes.delete();

            repeat (capture_pkg::SETTLE_CYCLES + 4) begin
                @(negedge adc_sampleclk);
                check_value("empty after reset", fifo_read_empty_o, 1'b1);
                check_value("valid while empty", fifo_read_valid_o, 1'b0);
                check_value("status after reset", |status_o, 1'b0);
            end

            repeat (row.go_cycles) begin
                @(posedge adc_sampleclk);
                rng_state = xorshift32(rng_state);
                adc_datain_i     <= rng_state[11:0];
                adc_write_mask_i <= rng_state[16];
                adc_capture_go_i <= 1'b1;
                fifo_read_en_i   <= ~row.stall;
            end
            @(posedge adc_sampleclk);
            adc_capture_go_i <= 1'b0;
            adc_write_mask_i <= 1'b0;
            fifo_read_en_i   <= 1'b1;

            // drained once the readout stays empty for a while
            idle   = 0;
            waited = 0;
            while (idle < 16 && waited < 400) begin
                @(negedge adc_sampleclk);
                idle   = fifo_read_empty_o ? idle + 1 : 0;
                waited = waited + 1;
            end
            if (idle < 16) begin
                err_count++;
                $display("test %0d: readout did not drain within 400 cycles", t);
            end

            build_expected(row.cfg);
            check_value("capture_stop", status_o.capture_stop, 1'b1);
            check_value("fifo_overflow", status_o.fifo_overflow, row.exp_ovf);
            if (row.cfg.stream_mode) begin
                check_value("samples within model", status_o.samples <= m_count, 1'b1);
                check_value("readout is a prefix",
                            got_bytes.size() > 0 && got_bytes.size() <= exp_bytes.size(), 1'b1);
            end else begin
                check_value("samples", status_o.samples, m_count);
                check_value("byte count", got_bytes.size(), exp_bytes.size());
            end
            if (row.exp_full)
                check_value("samples at stop", status_o.samples, capture_pkg::MAX_SAMPLES);
            for (int i = 0; i < got_bytes.size() && i < exp_bytes.size(); i++)
                check_value($sformatf("byte %0d", i), got_bytes[i], exp_bytes[i]);

            if (!row.cfg.low_res)
                res_name = "high res";
            else if (row.cfg.low_res_lsb)
                res_name = "low res lsb";
            else
                res_name = "low res msb";
            $display("test %0d %s %s ds=%0d: %0d samples, %0d bytes, %0d errors", t,
                     row.cfg.stream_mode ? "stream" : "normal", res_name,
                     row.cfg.downsample, status_o.samples, got_bytes.size(),
                     err_count - errs_before);
        end

        check_value("max_samples_o", max_samples_o, 32'd48);   // normal mode stop point
        err_count += DUT.u_chk.fail_count;   // assertion failures count too
        $display("%0d tests, %0d checks, %0d errors (%0d from assertions)",
                 $size(rows), check_count, err_count, DUT.u_chk.fail_count);
        if (err_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* compile.f */
design/capture_pkg.sv
design/sync_fifo.sv
design/capture_fsm.sv
design/capture_timer.sv
design/sample_packer.sv
design/byte_unpacker.sv
design/adc_capture_top.sv
sim/capture_chk.sv
sim/tb_adc_capture.sv
